// File: logic/sdram_cmd_ctrl.sv
// ----------------------------------------
// one access at a time, row closed by auto-precharge
// refresh beats a waiting strobe in IDLE
// stb_i, we_i and adr_i must stay stable until the ack
// ----------------------------------------
`default_nettype none

module sdram_cmd_ctrl (
	input  wire                              clk,
	input  wire                              reset,
	input  wire                              stb_i,
	input  wire                              we_i,
	input  wire  [sdram_pkg::ADR_WIDTH-1:0]  adr_i,
	input  wire                              init_busy_i,
	input  wire                              init_cke_i,
	input  wire  sdram_pkg::sdram_cmd_t      init_cmd_i,
	input  wire  [sdram_pkg::A_WIDTH-1:0]    init_a_i,
	input  wire  [sdram_pkg::BA_WIDTH-1:0]   init_ba_i,
	input  wire                              ref_req_i,
	output logic                             ref_ack_o,
	output logic                             cke_o,
	output logic                             cs_n_o,
	output sdram_pkg::sdram_cmd_t            cmd_o,
	output logic [sdram_pkg::BA_WIDTH-1:0]   ba_o,
	output logic [sdram_pkg::A_WIDTH-1:0]    a_o,
	output logic                             wr_start_o,
	output logic                             rd_start_o
);

	logic [sdram_pkg::STATE_WIDTH-1:0]    state;
	logic [sdram_pkg::STATE_WIDTH-1:0]    next_state;
	logic [sdram_pkg::CTRL_CNT_WIDTH-1:0] cnt;
	logic [sdram_pkg::CTRL_CNT_WIDTH-1:0] next_cnt;
	sdram_pkg::sdram_cmd_t                next_cmd;
	logic [sdram_pkg::BA_WIDTH-1:0]       next_ba;
	logic [sdram_pkg::A_WIDTH-1:0]        next_a;
	logic                                 next_wr_start;
	logic                                 next_rd_start;
	logic                                 next_ref_ack;

	logic [sdram_pkg::BA_WIDTH-1:0]       adr_ba;
	logic [sdram_pkg::ROW_WIDTH-1:0]      adr_row;
	logic [sdram_pkg::COL_WIDTH-1:0]      adr_col;

	// ----------------------------------------
	// address split: bank on top, column at the bottom
	assign adr_col = adr_i[sdram_pkg::COL_WIDTH-1:0];
	assign adr_row = adr_i[sdram_pkg::COL_WIDTH +: sdram_pkg::ROW_WIDTH];
	assign adr_ba  = adr_i[sdram_pkg::COL_WIDTH + sdram_pkg::ROW_WIDTH +: sdram_pkg::BA_WIDTH];

	// ----------------------------------------
	// next state and next command
	always_comb begin
		next_state    = state;
		next_cnt      = (cnt != '0) ? cnt - 1'b1 : cnt;
		next_cmd.code = sdram_pkg::CMD_NOP;
		next_ba       = ba_o;
		next_a        = a_o;
		next_wr_start = 1'b0;
		next_rd_start = 1'b0;
		next_ref_ack  = 1'b0;

		case (state)
		sdram_pkg::ST_IDLE: begin
			if (ref_req_i) begin
				next_cmd.code = sdram_pkg::CMD_REFRESH;
				next_ref_ack  = 1'b1;
				next_cnt      = sdram_pkg::CTRL_CNT_WIDTH'(sdram_pkg::TRFC_CYCLES - 1);
				next_state    = sdram_pkg::ST_REFRESH;
			end else if (stb_i) begin
				next_state = sdram_pkg::ST_ACTIVATING;
			end
		end
		sdram_pkg::ST_REFRESH: begin
			if (cnt == '0) begin
				next_state = sdram_pkg::ST_IDLE;
			end
		end
		sdram_pkg::ST_ACTIVATING: begin
			next_cmd.code = sdram_pkg::CMD_ACTIVE;
			next_ba       = adr_ba;
			next_a        = sdram_pkg::A_WIDTH'(adr_row);
			next_cnt      = sdram_pkg::CTRL_CNT_WIDTH'(sdram_pkg::TRCD_CYCLES - 1);
			next_state    = sdram_pkg::ST_ACCESS;
		end
		sdram_pkg::ST_ACCESS: begin
			if (cnt == '0) begin
				// read or write with auto-precharge
				next_cmd.code = we_i ? sdram_pkg::CMD_WRITE : sdram_pkg::CMD_READ;
				next_ba       = adr_ba;
				next_a        = sdram_pkg::A_WIDTH'(adr_col) | sdram_pkg::A_AUTO_PRECHARGE;
				next_wr_start = we_i;
				next_rd_start = !we_i;
				// rest of tRAS + tRP counted from ACTIVE
				next_cnt      = sdram_pkg::CTRL_CNT_WIDTH'(sdram_pkg::TRAS_CYCLES
					+ sdram_pkg::TRP_CYCLES - sdram_pkg::TRCD_CYCLES - 1);
				next_state    = sdram_pkg::ST_PRECHARGE_WAIT;
			end
		end
		sdram_pkg::ST_PRECHARGE_WAIT: begin
			if (cnt == '0) begin
				next_state = sdram_pkg::ST_IDLE;
			end
		end
		default: begin
			next_state = sdram_pkg::ST_IDLE;
		end
		endcase
	end

	// ----------------------------------------
	// registered pins, sequencer forwarded during init
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state      <= sdram_pkg::ST_IDLE;
			cnt        <= '0;
			cke_o      <= 1'b0;
			cs_n_o     <= 1'b1;
			cmd_o.code <= sdram_pkg::CMD_NOP;
			ba_o       <= '0;
			a_o        <= '0;
			wr_start_o <= 1'b0;
			rd_start_o <= 1'b0;
			ref_ack_o  <= 1'b0;
		end else if (init_busy_i) begin
			state      <= sdram_pkg::ST_IDLE;
			cnt        <= '0;
			cke_o      <= init_cke_i;
			cs_n_o     <= (init_cmd_i.code == sdram_pkg::CMD_NOP);
			cmd_o      <= init_cmd_i;
			ba_o       <= init_ba_i;
			a_o        <= init_a_i;
			wr_start_o <= 1'b0;
			rd_start_o <= 1'b0;
			ref_ack_o  <= 1'b0;
		end else begin
			state      <= next_state;
			cnt        <= next_cnt;
			cke_o      <= 1'b1;
			// deselect whenever nothing is issued
			cs_n_o     <= (next_cmd.code == sdram_pkg::CMD_NOP);
			cmd_o      <= next_cmd;
			ba_o       <= next_ba;
			a_o        <= next_a;
			wr_start_o <= next_wr_start;
			rd_start_o <= next_rd_start;
			ref_ack_o  <= next_ref_ack;
		end
	end

	// timing gaps carry NOP only
	assert property (@(posedge clk) disable iff (reset)
		(!init_busy_i && cnt != '0) |=> (cmd_o.code == sdram_pkg::CMD_NOP));

	// no row opened before power-up is over
	assert property (@(posedge clk) disable iff (reset)
		init_busy_i |-> (cmd_o.code != sdram_pkg::CMD_ACTIVE));

endmodule

`default_nettype wire

// File: logic/sdram_ctrl_top.sv
// ----------------------------------------
// SDRAM controller top, one 32-bit word per clk on dq
// dq is split into output, output enable and input
// master holds its request until the cycle after ack_o
// ----------------------------------------
`default_nettype none

module sdram_ctrl_top (
	input  wire                              clk,
	input  wire                              reset,
	input  wire                              endian_i,

	// bus side
	input  wire                              stb_i,
	input  wire                              we_i,
	input  wire  [sdram_pkg::ADR_WIDTH-1:0]  adr_i,
	input  wire  [sdram_pkg::DAT_WIDTH-1:0]  dat_i,
	input  wire  [sdram_pkg::SEL_WIDTH-1:0]  sel_i,
	output logic                             ack_o,
	output logic [sdram_pkg::DAT_WIDTH-1:0]  dat_o,

	// device side
	output logic                             sd_cke_o,
	output logic                             sd_cs_n_o,
	output logic                             sd_ras_n_o,
	output logic                             sd_cas_n_o,
	output logic                             sd_we_n_o,
	output logic [sdram_pkg::BA_WIDTH-1:0]   sd_ba_o,
	output logic [sdram_pkg::A_WIDTH-1:0]    sd_a_o,
	output logic [sdram_pkg::DAT_WIDTH-1:0]  sd_dq_o,
	output logic                             sd_dq_oe_o,
	output logic [sdram_pkg::SEL_WIDTH-1:0]  sd_dm_o,
	input  wire  [sdram_pkg::DAT_WIDTH-1:0]  sd_dq_i
);

	logic                            init_busy;
	logic                            init_cke;
	sdram_pkg::sdram_cmd_t           init_cmd;
	logic [sdram_pkg::A_WIDTH-1:0]   init_a;
	logic [sdram_pkg::BA_WIDTH-1:0]  init_ba;
	logic                            ref_req;
	logic                            ref_ack;
	sdram_pkg::sdram_cmd_t           cmd;
	logic                            wr_start;
	logic                            rd_start;

	sdram_init_seq u_init_seq (
		.clk         (clk),
		.reset       (reset),
		.init_busy_o (init_busy),
		.cke_o       (init_cke),
		.cmd_o       (init_cmd),
		.a_o         (init_a),
		.ba_o        (init_ba)
	);

	sdram_refresh_timer u_refresh_timer (
		.clk       (clk),
		.reset     (reset),
		.enable_i  (!init_busy),
		.ref_ack_i (ref_ack),
		.ref_req_o (ref_req)
	);

	sdram_cmd_ctrl u_cmd_ctrl (
		.clk         (clk),
		.reset       (reset),
		.stb_i       (stb_i),
		.we_i        (we_i),
		.adr_i       (adr_i),
		.init_busy_i (init_busy),
		.init_cke_i  (init_cke),
		.init_cmd_i  (init_cmd),
		.init_a_i    (init_a),
		.init_ba_i   (init_ba),
		.ref_req_i   (ref_req),
		.ref_ack_o   (ref_ack),
		.cke_o       (sd_cke_o),
		.cs_n_o      (sd_cs_n_o),
		.cmd_o       (cmd),
		.ba_o        (sd_ba_o),
		.a_o         (sd_a_o),
		.wr_start_o  (wr_start),
		.rd_start_o  (rd_start)
	);

	sdram_data_path u_data_path (
		.clk        (clk),
		.reset      (reset),
		.endian_i   (endian_i),
		.we_data_i  (dat_i),
		.sel_i      (sel_i),
		.wr_start_i (wr_start),
		.rd_start_i (rd_start),
		.sd_dq_i    (sd_dq_i),
		.sd_dq_o    (sd_dq_o),
		.sd_dq_oe_o (sd_dq_oe_o),
		.sd_dm_o    (sd_dm_o),
		.dat_o      (dat_o),
		.ack_o      (ack_o)
	);

	// pins from the bit view of the command
	assign sd_ras_n_o = cmd.pins.ras_n;
	assign sd_cas_n_o = cmd.pins.cas_n;
	assign sd_we_n_o  = cmd.pins.we_n;

endmodule

`default_nettype wire

// File: logic/sdram_data_path.sv
// ----------------------------------------
// write data is driven in the WRITE cycle from the held bus word
// read data is expected CAS_LATENCY cycles after the READ cycle
// endian_i swaps the halfwords of data and byte mask
// ----------------------------------------
`default_nettype none

module sdram_data_path (
	input  wire                              clk,
	input  wire                              reset,
	input  wire                              endian_i,
	input  wire  [sdram_pkg::DAT_WIDTH-1:0]  we_data_i,
	input  wire  [sdram_pkg::SEL_WIDTH-1:0]  sel_i,
	input  wire                              wr_start_i,
	input  wire                              rd_start_i,
	input  wire  [sdram_pkg::DAT_WIDTH-1:0]  sd_dq_i,
	output logic [sdram_pkg::DAT_WIDTH-1:0]  sd_dq_o,
	output logic                             sd_dq_oe_o,
	output logic [sdram_pkg::SEL_WIDTH-1:0]  sd_dm_o,
	output logic [sdram_pkg::DAT_WIDTH-1:0]  dat_o,
	output logic                             ack_o
);

	localparam int DW = sdram_pkg::DAT_WIDTH;
	localparam int SW = sdram_pkg::SEL_WIDTH;

	logic [sdram_pkg::CAS_LATENCY-1:0] rd_pipe;
	logic                              wr_ack;
	logic                              rd_ack;

	function automatic logic [DW-1:0] swap_word(
		input logic [DW-1:0] d,
		input logic          sw
	);
		return sw ? {d[DW/2-1:0], d[DW-1:DW/2]} : d;
	endfunction

	function automatic logic [SW-1:0] swap_sel(
		input logic [SW-1:0] s,
		input logic          sw
	);
		return sw ? {s[SW/2-1:0], s[SW-1:SW/2]} : s;
	endfunction

	// ----------------------------------------
	// write side, dm is active high mask
	assign sd_dq_o    = swap_word(we_data_i, endian_i);
	assign sd_dm_o    = ~swap_sel(sel_i, endian_i);
	assign sd_dq_oe_o = wr_start_i;

	// ----------------------------------------
	// read timing and acks
	// stages may overlap across back to back accesses
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rd_pipe <= '0;
			wr_ack  <= 1'b0;
			rd_ack  <= 1'b0;
		end else begin
			rd_pipe <= (rd_pipe << 1) | sdram_pkg::CAS_LATENCY'(rd_start_i);
			wr_ack  <= wr_start_i;
			rd_ack  <= rd_pipe[sdram_pkg::CAS_LATENCY-1];
		end
	end

	// capture at the end of the data cycle
	always_ff @(posedge clk) begin
		if (rd_pipe[sdram_pkg::CAS_LATENCY-1]) begin
			dat_o <= swap_word(sd_dq_i, endian_i);
		end
	end

	assign ack_o = wr_ack | rd_ack;

	// one access in flight, so acks never touch
	assert property (@(posedge clk) disable iff (reset)
		ack_o |=> !ack_o);

endmodule

`default_nettype wire

// File: logic/sdram_init_seq.sv
// ----------------------------------------
// power-up sequence: CKE low wait, precharge-all,
// two refreshes, mode load, then init_busy_o drops
// outputs are registered and must be forwarded to the pins
// ----------------------------------------
`default_nettype none

module sdram_init_seq (
	input  wire                             clk,
	input  wire                             reset,
	output logic                            init_busy_o,
	output logic                            cke_o,
	output sdram_pkg::sdram_cmd_t           cmd_o,
	output logic [sdram_pkg::A_WIDTH-1:0]   a_o,
	output logic [sdram_pkg::BA_WIDTH-1:0]  ba_o
);

	logic [sdram_pkg::STEP_WIDTH-1:0]     step;
	logic [sdram_pkg::INIT_CNT_WIDTH-1:0] cnt;

	// cnt is the gap before the next step acts
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			step        <= sdram_pkg::STEP_POWER_UP;
			cnt         <= sdram_pkg::INIT_CNT_WIDTH'(sdram_pkg::INIT_WAIT_CYCLES - 1);
			init_busy_o <= 1'b1;
			cke_o       <= 1'b0;
			cmd_o.code  <= sdram_pkg::CMD_NOP;
			a_o         <= '0;
			ba_o        <= '0;
		end else begin
			cmd_o.code <= sdram_pkg::CMD_NOP;
			if (cnt != '0) begin
				cnt <= cnt - 1'b1;
			end else begin
				case (step)
				sdram_pkg::STEP_POWER_UP: begin
					// CKE rises one cycle ahead of the first command
					cke_o <= 1'b1;
					step  <= sdram_pkg::STEP_PRECHARGE;
				end
				sdram_pkg::STEP_PRECHARGE: begin
					cmd_o.code <= sdram_pkg::CMD_PRECHARGE;
					a_o        <= sdram_pkg::A_AUTO_PRECHARGE;
					cnt        <= sdram_pkg::INIT_CNT_WIDTH'(sdram_pkg::TRP_CYCLES - 1);
					step       <= sdram_pkg::STEP_REFRESH_1;
				end
				sdram_pkg::STEP_REFRESH_1: begin
					cmd_o.code <= sdram_pkg::CMD_REFRESH;
					cnt        <= sdram_pkg::INIT_CNT_WIDTH'(sdram_pkg::TRFC_CYCLES - 1);
					step       <= sdram_pkg::STEP_REFRESH_2;
				end
				sdram_pkg::STEP_REFRESH_2: begin
					cmd_o.code <= sdram_pkg::CMD_REFRESH;
					cnt        <= sdram_pkg::INIT_CNT_WIDTH'(sdram_pkg::TRFC_CYCLES - 1);
					step       <= sdram_pkg::STEP_LOAD_MODE;
				end
				sdram_pkg::STEP_LOAD_MODE: begin
					// mode register gets a tRP sized settle gap
					cmd_o.code <= sdram_pkg::CMD_LOAD_MODE;
					a_o        <= sdram_pkg::MODE_REG_VALUE;
					ba_o       <= '0;
					cnt        <= sdram_pkg::INIT_CNT_WIDTH'(sdram_pkg::TRP_CYCLES - 1);
					step       <= sdram_pkg::STEP_DONE;
				end
				sdram_pkg::STEP_DONE: begin
					init_busy_o <= 1'b0;
				end
				default: begin
					step <= sdram_pkg::STEP_DONE;
				end
				endcase
			end
		end
	end

	// init commands never go out back to back
	assert property (@(posedge clk) disable iff (reset)
		(cmd_o.code != sdram_pkg::CMD_NOP) |=> (cmd_o.code == sdram_pkg::CMD_NOP));

endmodule

`default_nettype wire

// File: logic/sdram_pkg.sv
// ----------------------------------------
// geometry, timing and command encoding
// all timing is counted in clk cycles of one fixed clock
// INIT_WAIT_CYCLES is far below a real 200 us power-up wait
// ----------------------------------------
`default_nettype none

package sdram_pkg;

	// device geometry, bus address is {bank, row, column}
	localparam int BA_WIDTH  = 2;
	localparam int ROW_WIDTH = 13;
	localparam int COL_WIDTH = 9;
	localparam int A_WIDTH   = 13;
	localparam int ADR_WIDTH = BA_WIDTH + ROW_WIDTH + COL_WIDTH;

	localparam int DAT_WIDTH = 32;
	localparam int SEL_WIDTH = DAT_WIDTH / 8;

	// ----------------------------------------
	// timing in clk cycles
	localparam int INIT_WAIT_CYCLES = 200;
	localparam int TRCD_CYCLES      = 2;
	localparam int TRP_CYCLES       = 2;
	localparam int TRAS_CYCLES      = 5;
	localparam int TRFC_CYCLES      = 7;
	localparam int TREFI_CYCLES     = 780;
	localparam int CAS_LATENCY      = 2;

	localparam int INIT_CNT_WIDTH = $clog2(INIT_WAIT_CYCLES);
	localparam int REF_CNT_WIDTH  = $clog2(TREFI_CYCLES);
	localparam int CTRL_CNT_WIDTH = $clog2(TRFC_CYCLES + TRAS_CYCLES + TRP_CYCLES);

	// A10 selects auto-precharge and precharge-all
	localparam int AP_BIT = 10;
	localparam logic [A_WIDTH-1:0] A_AUTO_PRECHARGE = A_WIDTH'(1 << AP_BIT);

	// burst length 1, sequential, CAS latency in A[6:4]
	localparam logic [A_WIDTH-1:0] MODE_REG_VALUE = A_WIDTH'({3'(CAS_LATENCY), 1'b0, 3'b000});

	// ----------------------------------------
	// command codes are the {ras_n, cas_n, we_n} pin values
	localparam logic [2:0] CMD_LOAD_MODE = 3'b000;
	localparam logic [2:0] CMD_REFRESH   = 3'b001;
	localparam logic [2:0] CMD_PRECHARGE = 3'b010;
	localparam logic [2:0] CMD_ACTIVE    = 3'b011;
	localparam logic [2:0] CMD_WRITE     = 3'b100;
	localparam logic [2:0] CMD_READ      = 3'b101;
	localparam logic [2:0] CMD_NOP       = 3'b111;

	typedef union packed {
		logic [2:0] code;
		struct packed {
			logic ras_n;
			logic cas_n;
			logic we_n;
		} pins;
	} sdram_cmd_t;

	// control FSM states
	localparam int STATE_WIDTH = 3;
	localparam logic [STATE_WIDTH-1:0] ST_IDLE           = 3'd0;
	localparam logic [STATE_WIDTH-1:0] ST_REFRESH        = 3'd1;
	localparam logic [STATE_WIDTH-1:0] ST_ACTIVATING     = 3'd2;
	localparam logic [STATE_WIDTH-1:0] ST_ACCESS         = 3'd3;
	localparam logic [STATE_WIDTH-1:0] ST_PRECHARGE_WAIT = 3'd4;

	// power-up sequence steps
	localparam int STEP_WIDTH = 3;
	localparam logic [STEP_WIDTH-1:0] STEP_POWER_UP  = 3'd0;
	localparam logic [STEP_WIDTH-1:0] STEP_PRECHARGE = 3'd1;
	localparam logic [STEP_WIDTH-1:0] STEP_REFRESH_1 = 3'd2;
	localparam logic [STEP_WIDTH-1:0] STEP_REFRESH_2 = 3'd3;
	localparam logic [STEP_WIDTH-1:0] STEP_LOAD_MODE = 3'd4;
	localparam logic [STEP_WIDTH-1:0] STEP_DONE      = 3'd5;

endpackage

`default_nettype wire

// File: logic/sdram_refresh_timer.sv
// ----------------------------------------
// refresh interval timer
// request stays set until the controller acks it
// ----------------------------------------
`default_nettype none

module sdram_refresh_timer (
	input  wire  clk,
	input  wire  reset,
	input  wire  enable_i,
	input  wire  ref_ack_i,
	output logic ref_req_o
);

	localparam logic [sdram_pkg::REF_CNT_WIDTH-1:0] RELOAD =
		sdram_pkg::REF_CNT_WIDTH'(sdram_pkg::TREFI_CYCLES - 1);

	logic [sdram_pkg::REF_CNT_WIDTH-1:0] cnt;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cnt       <= RELOAD;
			ref_req_o <= 1'b0;
		end else begin
			// held at full interval while disabled
			if (!enable_i || cnt == '0) begin
				cnt <= RELOAD;
			end else begin
				cnt <= cnt - 1'b1;
			end

			// expiry wins over a coinciding ack
			if (enable_i && cnt == '0) begin
				ref_req_o <= 1'b1;
			end else if (ref_ack_i) begin
				ref_req_o <= 1'b0;
			end
		end
	end

	// controller only acks a pending request
	assert property (@(posedge clk) disable iff (reset)
		ref_ack_i |-> ref_req_o);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the SDRAM controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_sdram_ctrl \
	-f sources.f \
	--Mdir obj_dir -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
	exit 1
fi
exit 0

// File: sources.f
logic/sdram_pkg.sv
logic/sdram_init_seq.sv
logic/sdram_refresh_timer.sv
logic/sdram_cmd_ctrl.sv
logic/sdram_data_path.sv
logic/sdram_ctrl_top.sv
testbench/sdram_model.sv
testbench/tb_sdram_ctrl.sv

// File: testbench/sdram_model.sv
// ----------------------------------------
// behavioral SDRAM, one 32-bit word per clk, burst length 1
// storage keyed by {bank, row, column}, unwritten words read a fill
// protocol faults are raised on fault_o and stay set
// ----------------------------------------
`default_nettype none

module sdram_model (
	input  wire                              clk,
	input  wire                              reset,
	input  wire                              cke_i,
	input  wire                              cs_n_i,
	input  wire                              ras_n_i,
	input  wire                              cas_n_i,
	input  wire                              we_n_i,
	input  wire  [sdram_pkg::BA_WIDTH-1:0]   ba_i,
	input  wire  [sdram_pkg::A_WIDTH-1:0]    a_i,
	input  wire  [sdram_pkg::DAT_WIDTH-1:0]  dq_i,
	input  wire                              dq_oe_i,
	input  wire  [sdram_pkg::SEL_WIDTH-1:0]  dm_i,
	output logic [sdram_pkg::DAT_WIDTH-1:0]  dq_o,
	output logic                             init_done_o,
	output logic                             fault_o
);

	localparam int CL        = sdram_pkg::CAS_LATENCY;
	localparam int NBANK     = 1 << sdram_pkg::BA_WIDTH;
	localparam int INIT_DONE = 4;
	// worst case wait of a refresh behind one access
	localparam int ACCESS_CYCLES = sdram_pkg::TRCD_CYCLES + sdram_pkg::TRAS_CYCLES
		+ sdram_pkg::TRP_CYCLES + sdram_pkg::TRFC_CYCLES + 4;
	localparam int REF_LIMIT = sdram_pkg::TREFI_CYCLES + ACCESS_CYCLES;
	localparam logic [31:0] IDLE_DQ = 32'hdead_beef;

	logic [31:0] mem [logic [23:0]];
	logic [31:0] dq_pipe [CL];
	logic        open_valid [NBANK];
	logic [sdram_pkg::ROW_WIDTH-1:0] open_row [NBANK];
	int          act_cycle [NBANK];
	int          cycle;
	int          last_ref;
	int          init_step;
	int          i;
	logic [2:0]  cmd;
	logic [23:0] key;
	logic [31:0] word;

	function automatic logic [31:0] fill_word(input logic [23:0] k);
		return {k[7:0], k} ^ 32'h5a3c_96e1;
	endfunction

	task automatic report_fault(input string msg);
		$display("sdram_model: %s at cycle %0d", msg, cycle);
		fault_o <= 1'b1;
	endtask

	assign dq_o        = dq_pipe[CL-1];
	assign init_done_o = (init_step == INIT_DONE);

	// ----------------------------------------
	// power-up order: precharge-all, refresh, refresh, mode load
	task automatic check_init_cmd();
		case (init_step)
		0: begin
			if (cmd == sdram_pkg::CMD_PRECHARGE && a_i[sdram_pkg::AP_BIT])
				init_step <= 1;
			else
				report_fault("expected precharge-all as first init command");
		end
		1, 2: begin
			if (cmd == sdram_pkg::CMD_REFRESH)
				init_step <= init_step + 1;
			else
				report_fault("expected auto-refresh during init");
		end
		default: begin
			if (cmd == sdram_pkg::CMD_LOAD_MODE && a_i[6:4] == 3'(CL) && a_i[2:0] == 3'd0) begin
				init_step <= INIT_DONE;
				last_ref  <= cycle;
			end else begin
				report_fault("expected mode load with CAS latency 2 and burst length 1");
			end
		end
		endcase
	endtask

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			cycle     <= 0;
			last_ref  <= 0;
			init_step <= 0;
			fault_o   <= 1'b0;
			for (i = 0; i < NBANK; i++) begin
				open_valid[i] <= 1'b0;
				act_cycle[i]  <= 0;
			end
			for (i = 0; i < CL; i++)
				dq_pipe[i] <= IDLE_DQ;
		end else begin
			cycle <= cycle + 1;
			for (i = CL - 1; i > 0; i--)
				dq_pipe[i] <= dq_pipe[i-1];
			dq_pipe[0] <= IDLE_DQ;
			cmd = {ras_n_i, cas_n_i, we_n_i};

			if (init_step == INIT_DONE && cycle - last_ref > REF_LIMIT)
				report_fault("refresh interval exceeded");

			if (!cs_n_i && cmd != sdram_pkg::CMD_NOP) begin
				if (!cke_i) begin
					report_fault("command issued with CKE low");
				end else if (init_step != INIT_DONE) begin
					check_init_cmd();
				end else begin
					case (cmd)
					sdram_pkg::CMD_ACTIVE: begin
						if (open_valid[ba_i]) begin
							report_fault("ACTIVE to a bank with an open row");
						end else begin
							open_valid[ba_i] <= 1'b1;
							open_row[ba_i]   <= a_i[sdram_pkg::ROW_WIDTH-1:0];
							act_cycle[ba_i]  <= cycle;
						end
					end
					sdram_pkg::CMD_READ, sdram_pkg::CMD_WRITE: begin
						if (!open_valid[ba_i]) begin
							report_fault("access to a bank with no open row");
						end else if (cycle - act_cycle[ba_i] < sdram_pkg::TRCD_CYCLES) begin
							report_fault("ACTIVE to READ/WRITE gap below tRCD");
						end else if (!a_i[sdram_pkg::AP_BIT]) begin
							report_fault("access without auto-precharge");
						end else begin
							key = {ba_i, open_row[ba_i], a_i[sdram_pkg::COL_WIDTH-1:0]};
							word = mem.exists(key) ? mem[key] : fill_word(key);
							open_valid[ba_i] <= 1'b0;
							if (cmd == sdram_pkg::CMD_READ) begin
								dq_pipe[0] <= word;
							end else if (!dq_oe_i) begin
								report_fault("WRITE without dq output enable");
							end else begin
								// dm high masks a byte
								for (i = 0; i < 4; i++)
									if (!dm_i[i])
										word[8*i +: 8] = dq_i[8*i +: 8];
								mem[key] = word;
							end
						end
					end
					sdram_pkg::CMD_REFRESH: begin
						for (i = 0; i < NBANK; i++)
							if (open_valid[i])
								report_fault("REFRESH with a row open");
						last_ref <= cycle;
					end
					sdram_pkg::CMD_PRECHARGE: begin
						for (i = 0; i < NBANK; i++)
							if (a_i[sdram_pkg::AP_BIT] || ba_i == i[1:0])
								open_valid[i] <= 1'b0;
					end
					default: begin
						report_fault("unexpected command after init");
					end
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/tb_sdram_ctrl.sv
// ----------------------------------------
// testbench for the SDRAM controller with a behavioral model
// shadow memory holds words as stored in the device
// endian_i only changes while no access is pending
// ----------------------------------------
`default_nettype none

module tb_sdram_ctrl;

	localparam int N_FULL    = 8;
	localparam int N_MERGE   = 60;
	localparam int N_STREAM  = 400;
	localparam int N_ENDIAN  = 6;
	localparam int N_LONG    = 600;
	localparam int N_TOTAL   = N_FULL + N_MERGE + N_STREAM + N_ENDIAN + N_LONG;
	localparam int ROW_CYCLE = sdram_pkg::TRAS_CYCLES + sdram_pkg::TRP_CYCLES;
	localparam longint LIMIT_CYCLES = 20 + sdram_pkg::INIT_WAIT_CYCLES + 40
		+ longint'(N_TOTAL) * (sdram_pkg::TRFC_CYCLES + ROW_CYCLE + 20);

	logic        clk;
	logic        reset;
	logic        endian;
	logic        stb;
	logic        we;
	logic [23:0] adr;
	logic [31:0] dat;
	logic [3:0]  sel;
	logic        ack;
	logic [31:0] dat_rd;

	logic        sd_cke;
	logic        sd_cs_n;
	logic        sd_ras_n;
	logic        sd_cas_n;
	logic        sd_we_n;
	logic [1:0]  sd_ba;
	logic [12:0] sd_a;
	logic [31:0] sd_dq_out;
	logic        sd_dq_oe;
	logic [3:0]  sd_dm;
	logic [31:0] sd_dq_in;
	logic        model_init_done;
	logic        model_fault;

	logic [31:0] shadow [logic [23:0]];
	logic [23:0] written_q [$];
	bit          exp_read_q [$];
	logic [31:0] exp_data_q [$];
	int          strobes_issued;
	int          acks_seen;
	bit          cmp_is_read;
	logic [31:0] cmp_exp;

	sdram_ctrl_top uut (
		.clk        (clk),
		.reset      (reset),
		.endian_i   (endian),
		.stb_i      (stb),
		.we_i       (we),
		.adr_i      (adr),
		.dat_i      (dat),
		.sel_i      (sel),
		.ack_o      (ack),
		.dat_o      (dat_rd),
		.sd_cke_o   (sd_cke),
		.sd_cs_n_o  (sd_cs_n),
		.sd_ras_n_o (sd_ras_n),
		.sd_cas_n_o (sd_cas_n),
		.sd_we_n_o  (sd_we_n),
		.sd_ba_o    (sd_ba),
		.sd_a_o     (sd_a),
		.sd_dq_o    (sd_dq_out),
		.sd_dq_oe_o (sd_dq_oe),
		.sd_dm_o    (sd_dm),
		.sd_dq_i    (sd_dq_in)
	);

	sdram_model u_model (
		.clk         (clk),
		.reset       (reset),
		.cke_i       (sd_cke),
		.cs_n_i      (sd_cs_n),
		.ras_n_i     (sd_ras_n),
		.cas_n_i     (sd_cas_n),
		.we_n_i      (sd_we_n),
		.ba_i        (sd_ba),
		.a_i         (sd_a),
		.dq_i        (sd_dq_out),
		.dq_oe_i     (sd_dq_oe),
		.dm_i        (sd_dm),
		.dq_o        (sd_dq_in),
		.init_done_o (model_init_done),
		.fault_o     (model_fault)
	);

	always #5 clk = ~clk;

	// ----------------------------------------
	// reference model
	function automatic logic [31:0] halfword_swap(input logic [31:0] d);
		return {d[15:0], d[31:16]};
	endfunction

	function automatic logic [31:0] device_word(input logic [23:0] a);
		if (shadow.exists(a))
			return shadow[a];
		return {a[7:0], a} ^ 32'h5a3c_96e1;
	endfunction

	// bus view of the stored word
	function automatic logic [31:0] expected_word(input logic [23:0] a, input logic e);
		return e ? halfword_swap(device_word(a)) : device_word(a);
	endfunction

	task automatic merge_write(input logic [23:0] a, input logic [31:0] d, input logic [3:0] s);
		logic [31:0] w;
		logic [31:0] dd;
		logic [3:0]  ds;
		w  = device_word(a);
		dd = endian ? halfword_swap(d) : d;
		ds = endian ? {s[1:0], s[3:2]} : s;
		for (int b = 0; b < 4; b++)
			if (ds[b])
				w[8*b +: 8] = dd[8*b +: 8];
		shadow[a] = w;
		written_q.push_back(a);
	endtask

	// ----------------------------------------
	task automatic fail_run();
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (exp !== got) begin
			$display("ERR %s exp=%h got=%h", name, exp, got);
			fail_run();
		end
	endtask

	task automatic bus_access(input logic w, input logic [23:0] a, input logic [31:0] d,
		input logic [3:0] s);
		@(posedge clk);
		#1;
		stb = 1'b1;
		we  = w;
		adr = a;
		dat = d;
		sel = s;
		strobes_issued++;
		exp_read_q.push_back(!w);
		exp_data_q.push_back(w ? 32'h0 : expected_word(a, endian));
		if (w)
			merge_write(a, d, s);
		@(posedge clk);
		while (!ack)
			@(posedge clk);
		#1;
		stb = 1'b0;
		we  = 1'b0;
	endtask

	function automatic logic [23:0] pick_addr();
		if (written_q.size() != 0 && $urandom() % 2 == 0)
			return written_q[$urandom() % written_q.size()];
		return 24'($urandom());
	endfunction

	task automatic random_stream(input int n, input bit toggle_endian);
		for (int k = 0; k < n; k++) begin
			if (toggle_endian && $urandom() % 16 == 0)
				endian = ~endian;
			bus_access(1'($urandom() % 2), pick_addr(), $urandom(), 4'($urandom()));
		end
	endtask

	// ----------------------------------------
	// compare process, one expected entry per ack
	always @(posedge clk) begin
		if (!reset && ack) begin
			if (exp_read_q.size() == 0) begin
				$display("ack_o pulsed with no strobe outstanding");
				fail_run();
			end else begin
				cmp_is_read = exp_read_q.pop_front();
				cmp_exp     = exp_data_q.pop_front();
				acks_seen++;
				if (cmp_is_read)
					check_value("dat_o", cmp_exp, dat_rd);
			end
		end
	end

	always @(posedge clk) begin
		if (model_fault) begin
			$display("memory model flagged a protocol fault");
			fail_run();
		end
	end

	// watchdog
	initial begin
		#(LIMIT_CYCLES * 10);
		$display("watchdog expired before the tests finished");
		fail_run();
	end

	// ----------------------------------------
	initial begin
		logic [23:0] a;
		logic [31:0] d;
		void'($urandom(32'hcaeeac8a));
		clk    = 1'b0;
		reset  = 1'b1;
		endian = 1'b0;
		stb    = 1'b0;
		we     = 1'b0;
		adr    = '0;
		dat    = '0;
		sel    = '0;
		strobes_issued = 0;
		acks_seen      = 0;
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;

		// CKE low and no ack through the power-up wait
		repeat (sdram_pkg::INIT_WAIT_CYCLES) begin
			@(posedge clk);
			check_value("sd_cke_o", 32'h0, 32'(sd_cke));
			check_value("ack_o", 32'h0, 32'(ack));
		end
		while (!model_init_done) begin
			@(posedge clk);
			check_value("ack_o", 32'h0, 32'(ack));
		end

		// full word write then read, one per bank
		for (int k = 0; k < N_FULL / 2; k++) begin
			a = {2'(k), 22'($urandom())};
			bus_access(1'b1, a, $urandom(), 4'hf);
			bus_access(1'b0, a, 32'h0, 4'h0);
		end

		// byte merges over a small address pool
		for (int k = 0; k < N_MERGE; k++)
			bus_access($urandom() % 3 != 0, {2'd1, 13'h0a5, 6'd0, 3'($urandom())},
				$urandom(), 4'($urandom()));

		random_stream(N_STREAM, 1'b0);

		// halfwords swapped in the stored word with endian high
		endian = 1'b1;
		a = 24'h9abcde;
		d = 32'h1234_5678;
		bus_access(1'b1, a, d, 4'hf);
		bus_access(1'b0, a, 32'h0, 4'h0);
		check_value("stored_word", halfword_swap(d), u_model.mem[a]);
		endian = 1'b0;
		a = 24'h1bcdef;
		bus_access(1'b1, a, d, 4'hf);
		bus_access(1'b0, a, 32'h0, 4'h0);
		check_value("stored_word", d, u_model.mem[a]);
		bus_access(1'b0, 24'h9abcde, 32'h0, 4'h0);
		bus_access(1'b0, 24'h1bcdef, 32'h0, 4'h0);

		// long stream spans several refresh intervals
		random_stream(N_LONG, 1'b1);

		repeat (20) @(posedge clk);
		if (acks_seen != strobes_issued) begin
			$display("ack count %0d does not match strobe count %0d", acks_seen, strobes_issued);
			fail_run();
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
